// ==== include/sd_tx_params.svh ====
// Size and polynomial constants for the SD transmit formatter, included by package and RTL
`ifndef SD_TX_PARAMS_SVH
`define SD_TX_PARAMS_SVH

//////////////////////////////////////////
// Stream and bus word
//////////////////////////////////////////

// Width of both the input stream word and the output slot word
`define SD_WORD_W	32

// Each line byte repeats this many times in one output word
`define SD_LANE_REP	4

// Number of data lines in 4-wire mode
`define SD_LINES_4W	4

//////////////////////////////////////////
// CRC
//////////////////////////////////////////

`define SD_CRC_W	16

// CRC-16 CCITT polynomial, x^16 + x^12 + x^5 + 1
`define SD_CRC_POLY	16'h1021

`endif

// ==== source/sd_tx_pkg.sv ====
// Shared types and the bitwise CRC step used by every block of the SD transmit formatter
`include "sd_tx_params.svh"

package sd_tx_pkg;

	// Line count of the bus
	// Encoding 2'b10 stays reserved for 8-wire
	typedef enum logic [1:0] {
		WIDTH_1W = 2'b00,
		WIDTH_4W = 2'b01
	} bus_width_t;

	// Framer state
	typedef enum logic [1:0] {
		PH_IDLE = 2'b00,
		PH_DATA = 2'b01,
		PH_CRC  = 2'b10,
		PH_LAST = 2'b11
	} frame_phase_t;

	typedef logic [`SD_WORD_W-1:0] word_t;

	//////////////////////////////////////////
	// CRC-16 advance by one bit
	//////////////////////////////////////////

	function automatic logic [`SD_CRC_W-1:0] crc_step(
		input logic [`SD_CRC_W-1:0] prior,
		input logic din
	);
		logic [`SD_CRC_W-1:0] shifted;

		shifted = {prior[`SD_CRC_W-2:0], 1'b0};
		// Feedback is the outgoing top bit against the new data bit
		if (prior[`SD_CRC_W-1] ^ din)
			return shifted ^ `SD_CRC_POLY;
		return shifted;
	endfunction

endpackage

// ==== source/sd_word_if.sv ====
// Word handoff between the framer and the line serializer, one word per transfer
`timescale 1ns/1ns

interface sd_word_if
	import sd_tx_pkg::*;
();

	logic start;
	logic valid;
	word_t data;
	// Word in data is a CRC word
	logic crc_phase;
	logic ready;
	// Serializer still has a frame on the lines
	logic busy;

	modport framer_mp (
		output start, valid, data, crc_phase,
		input ready, busy
	);

	modport serializer_mp (
		input start, valid, data, crc_phase,
		output ready, busy
	);

endinterface

// ==== source/sd_tx_framer.sv ====
// Frame FSM, accepts the input stream and feeds payload then CRC words to the serializer
`timescale 1ns/1ns

module sd_tx_framer
	import sd_tx_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input logic i_en,
	input logic i_ckstb,
	input bus_width_t i_cfg_width,
	input logic i_s_valid,
	input word_t i_s_data,
	input logic i_s_last,
	input word_t i_crc_word,
	output logic o_s_ready,
	output logic o_beat,
	output logic o_crc_shift,
	output logic o_clear,
	output bus_width_t o_width,
	sd_word_if.framer_mp word
);

	frame_phase_t phase;
	bus_width_t width_q;
	logic valid_q;
	logic crc_phase_q;
	word_t data_q;
	// Set while a second CRC word is still to come
	logic crc_more;
	logic xfer;

	assign xfer = valid_q && word.ready;

	assign word.start = i_en && i_s_valid && i_ckstb && (phase == PH_IDLE) && !word.busy;
	assign word.valid = valid_q;
	assign word.data = data_q;
	assign word.crc_phase = crc_phase_q;

	assign o_s_ready = word.ready
		&& ((phase == PH_DATA) || ((phase == PH_IDLE) && i_en && !word.busy));
	assign o_beat = i_s_valid && o_s_ready;
	assign o_crc_shift = xfer && (phase == PH_CRC);
	assign o_clear = (phase == PH_IDLE);

	// Live width while idle so a frame starting now sees it
	assign o_width = (phase == PH_IDLE) ? i_cfg_width : width_q;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			width_q <= WIDTH_1W;
		else if (phase == PH_IDLE)
			width_q <= i_cfg_width;
	end

	//////////////////////////////////////////
	// Phase sequencing
	//////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			phase <= PH_IDLE;
			valid_q <= 1'b0;
			crc_phase_q <= 1'b0;
			crc_more <= 1'b0;
		end else begin
			case (phase)
			PH_IDLE: begin
				crc_more <= (o_width == WIDTH_4W);
				if (word.start) begin
					valid_q <= 1'b1;
					phase <= i_s_last ? PH_CRC : PH_DATA;
				end
			end
			PH_DATA: begin
				if (word.ready) begin
					valid_q <= i_s_valid;
					if (i_s_valid && i_s_last)
						phase <= PH_CRC;
				end
			end
			PH_CRC: begin
				if (xfer) begin
					crc_phase_q <= 1'b1;
					crc_more <= 1'b0;
					if (!crc_more)
						phase <= PH_LAST;
				end
			end
			PH_LAST: begin
				// Wait here until the stop slot has gone out
				if (xfer) begin
					valid_q <= 1'b0;
					crc_phase_q <= 1'b0;
				end else if (!valid_q && !word.busy) begin
					phase <= PH_IDLE;
				end
			end
			default: phase <= PH_IDLE;
			endcase
		end
	end

	// Payload then CRC words
	always_ff @(posedge i_clk) begin
		if (o_beat)
			data_q <= i_s_data;
		else if (o_crc_shift)
			data_q <= i_crc_word;
	end

	a_idle_no_word: assert property (@(posedge i_clk) disable iff (i_reset)
		(phase == PH_IDLE) |-> !valid_q);

endmodule

// ==== source/sd_tx_crc.sv ====
// Per-line CRC-16 over the accepted payload and the CRC words handed back to the framer
`timescale 1ns/1ns
`include "sd_tx_params.svh"

module sd_tx_crc
	import sd_tx_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input bus_width_t i_width,
	input logic i_beat,
	input logic i_crc_shift,
	input logic i_clear,
	input word_t i_s_data,
	output word_t o_crc_word
);

	localparam int CRC4_W = `SD_CRC_W * `SD_LINES_4W;
	localparam int BITS_PER_LINE = `SD_WORD_W / `SD_LINES_4W;

	logic [`SD_CRC_W-1:0] crc_1w;
	logic [`SD_CRC_W-1:0] nxt_1w;
	// Interleaved, bit k*4+j is bit k of line j
	logic [CRC4_W-1:0] crc_4w;
	logic [CRC4_W-1:0] nxt_4w;
	logic [`SD_CRC_W-1:0] lane;

	//////////////////////////////////////////
	// Next CRC values for one input word
	//////////////////////////////////////////

	always_comb begin
		// A word taken while idle starts a fresh frame
		nxt_1w = i_clear ? '0 : crc_1w;
		for (int b = 0; b < `SD_WORD_W; b++)
			nxt_1w = crc_step(nxt_1w, i_s_data[`SD_WORD_W-1-b]);

		nxt_4w = '0;
		lane = '0;
		for (int j = 0; j < `SD_LINES_4W; j++) begin
			// Pull line j out of the interleave
			for (int k = 0; k < `SD_CRC_W; k++)
				lane[k] = i_clear ? 1'b0 : crc_4w[k*`SD_LINES_4W+j];
			// Line j carries bits j, j+4, j+8 ... MSB first
			for (int b = 0; b < BITS_PER_LINE; b++)
				lane = crc_step(lane,
					i_s_data[`SD_WORD_W-`SD_LINES_4W-`SD_LINES_4W*b+j]);
			for (int k = 0; k < `SD_CRC_W; k++)
				nxt_4w[k*`SD_LINES_4W+j] = lane[k];
		end
	end

	//////////////////////////////////////////
	// CRC registers
	//////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			crc_1w <= '0;
			crc_4w <= '0;
		end else if (i_beat) begin
			crc_1w <= nxt_1w;
			crc_4w <= nxt_4w;
		end else if (i_crc_shift) begin
			// Next 32 interleaved bits move to the top
			crc_4w <= {crc_4w[CRC4_W-`SD_WORD_W-1:0], {`SD_WORD_W{1'b1}}};
		end else if (i_clear) begin
			crc_1w <= '0;
			crc_4w <= '0;
		end
	end

	// 1-wire CRC fills only the upper half, the rest idles high
	assign o_crc_word = (i_width == WIDTH_4W) ? crc_4w[CRC4_W-1 -: `SD_WORD_W]
		: {crc_1w, {(`SD_WORD_W-`SD_CRC_W){1'b1}}};

	a_beat_not_shift: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_beat && i_crc_shift));

endmodule

// ==== source/sd_tx_serializer.sv ====
// Line serializer, turns framer words into per-slot bus words with start and stop slots
`timescale 1ns/1ns
`include "sd_tx_params.svh"

module sd_tx_serializer
	import sd_tx_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input logic i_ckstb,
	input bus_width_t i_width,
	output logic o_tx_valid,
	output word_t o_tx_data,
	sd_word_if.serializer_mp word
);

	// Slots left after the current one
	logic [4:0] count;
	logic stop_flag;
	word_t sreg;
	word_t src;
	word_t slot_word;
	word_t shifted;
	logic [4:0] load_count;

	assign word.ready = (count == '0) && i_ckstb;
	assign word.busy = o_tx_valid;

	//////////////////////////////////////////
	// Slot formatting
	//////////////////////////////////////////

	// New word on a transfer, else keep draining
	assign src = word.ready ? word.data : sreg;

	always_comb begin
		if (i_width == WIDTH_4W) begin
			slot_word = {`SD_LANE_REP{4'hf, src[`SD_WORD_W-1 -: 4]}};
			shifted = {src[`SD_WORD_W-5:0], 4'hf};
			load_count = 5'd7;
		end else begin
			slot_word = {`SD_LANE_REP{7'h7f, src[`SD_WORD_W-1]}};
			shifted = {src[`SD_WORD_W-2:0], 1'b1};
			// 1-wire CRC holds only 16 bits
			load_count = word.crc_phase ? 5'd15 : 5'd31;
		end
	end

	//////////////////////////////////////////
	// Slot control
	//////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_tx_valid <= 1'b0;
			stop_flag <= 1'b0;
			count <= '0;
		end else if (word.start) begin
			o_tx_valid <= 1'b1;
			stop_flag <= 1'b1;
		end else if (word.ready) begin
			if (word.valid) begin
				o_tx_valid <= 1'b1;
				stop_flag <= 1'b1;
				count <= load_count;
			end else begin
				// One all-ones stop slot, then the bus goes idle
				o_tx_valid <= stop_flag;
				stop_flag <= 1'b0;
			end
		end else if (i_ckstb && (count != '0)) begin
			count <= count - 5'd1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_tx_data <= '1;
		else if (word.start)
			o_tx_data <= (i_width == WIDTH_4W) ? {`SD_LANE_REP{8'hf0}}
				: {`SD_LANE_REP{8'hfe}};
		else if (word.ready)
			o_tx_data <= word.valid ? slot_word : '1;
		else if (i_ckstb && (count != '0))
			o_tx_data <= slot_word;
	end

	// Shift register
	always_ff @(posedge i_clk) begin
		if (i_ckstb)
			sreg <= shifted;
	end

	a_idle_high: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_tx_valid |-> (&o_tx_data));

	a_hold_between_strobes: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_ckstb |=> ($stable(o_tx_data) && $stable(o_tx_valid)));

endmodule

// ==== source/sd_tx_frame.sv ====
// Top of the SD transmit frame formatter, connects framer, CRC and serializer
`timescale 1ns/1ns

module sd_tx_frame
	import sd_tx_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input bus_width_t i_cfg_width,
	input logic i_en,
	input logic i_ckstb,
	input logic i_s_valid,
	input word_t i_s_data,
	input logic i_s_last,
	output logic o_s_ready,
	output logic o_tx_valid,
	output word_t o_tx_data
);

	logic beat;
	logic crc_shift;
	logic clear;
	bus_width_t width;
	word_t crc_word;

	sd_word_if u_word ();

	sd_tx_framer u_framer (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_en (i_en),
		.i_ckstb (i_ckstb),
		.i_cfg_width (i_cfg_width),
		.i_s_valid (i_s_valid),
		.i_s_data (i_s_data),
		.i_s_last (i_s_last),
		.i_crc_word (crc_word),
		.o_s_ready (o_s_ready),
		.o_beat (beat),
		.o_crc_shift (crc_shift),
		.o_clear (clear),
		.o_width (width),
		.word (u_word.framer_mp)
	);

	sd_tx_crc u_crc (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_width (width),
		.i_beat (beat),
		.i_crc_shift (crc_shift),
		.i_clear (clear),
		.i_s_data (i_s_data),
		.o_crc_word (crc_word)
	);

	sd_tx_serializer u_serializer (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_ckstb (i_ckstb),
		.i_width (width),
		.o_tx_valid (o_tx_valid),
		.o_tx_data (o_tx_data),
		.word (u_word.serializer_mp)
	);

endmodule

// ==== tests/tb_sd_tx_frame.sv ====
// Self-checking testbench for the SD transmit frame formatter, run as the simulation top
`timescale 1ns/1ns

module tb_sd_tx_frame
	import sd_tx_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	// Payload words over all frames sent below
	localparam int TOTAL_WORDS = 1 + 5 + 3 + 2 + 4;
	// 64 slots per word, about 4 cycles per slot, plus reset and idle tail
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 64 * 4 + 50;

	logic i_clk;
	logic i_reset;
	bus_width_t i_cfg_width;
	logic i_en;
	logic i_ckstb;
	logic i_s_valid;
	word_t i_s_data;
	logic i_s_last;
	logic o_s_ready;
	logic o_tx_valid;
	word_t o_tx_data;

	integer seed;
	// Expected bus slots, oldest first
	word_t exp_q[$];
	logic strobe_at_edge;
	word_t last_data;
	logic last_valid;
	logic drained;

	sd_tx_frame u_dut (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_cfg_width (i_cfg_width),
		.i_en (i_en),
		.i_ckstb (i_ckstb),
		.i_s_valid (i_s_valid),
		.i_s_data (i_s_data),
		.i_s_last (i_s_last),
		.o_s_ready (o_s_ready),
		.o_tx_valid (o_tx_valid),
		.o_tx_data (o_tx_data)
	);

	initial i_clk = 1'b0;
	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	////////////////////////////////////////
	// Failure reporting and checks
	////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// CRC-16 over x^16 + x^12 + x^5 + 1 advanced by one input bit
	function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic bit_in);
		logic fb;

		fb = crc[15] ^ bit_in;
		crc16_next = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
	endfunction

	// Appends the slot words of one frame to the expected queue
	function automatic void sd_frame_model(input word_t words[$], input logic wide);
		logic [15:0] crc_one;
		logic [15:0] crc_line [0:3];
		logic [3:0] nib;
		word_t cur;
		int w;
		int n;
		int j;
		int k;

		crc_one = '0;
		for (j = 0; j < 4; j++)
			crc_line[j] = '0;
		exp_q.push_back(wide ? 32'hf0f0f0f0 : 32'hfefefefe);
		for (w = 0; w < words.size(); w++) begin
			cur = words[w];
			if (wide) begin
				// Nibble bit j goes out on line j
				for (n = 7; n >= 0; n--) begin
					nib = cur[n*4 +: 4];
					exp_q.push_back({4{4'hf, nib}});
					for (j = 0; j < 4; j++)
						crc_line[j] = crc16_next(crc_line[j], nib[j]);
				end
			end else begin
				for (n = 31; n >= 0; n--) begin
					exp_q.push_back({4{7'h7f, cur[n]}});
					crc_one = crc16_next(crc_one, cur[n]);
				end
			end
		end
		// CRC slots MSB first
		for (k = 15; k >= 0; k--) begin
			if (wide) begin
				nib = {crc_line[3][k], crc_line[2][k], crc_line[1][k], crc_line[0][k]};
				exp_q.push_back({4{4'hf, nib}});
			end else begin
				exp_q.push_back({4{7'h7f, crc_one[k]}});
			end
		end
		exp_q.push_back(32'hffffffff);
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Next rising edge, then a fresh random strobe
	task automatic next_cycle();
		integer rnd;

		@(posedge i_clk);
		#1;
		rnd = $random(seed);
		i_ckstb = rnd[0];
	endtask

	task automatic send_frame(input int nwords, input logic wide);
		word_t words[$];
		integer rnd;
		int idx;
		logic accepted;

		for (idx = 0; idx < nwords; idx++) begin
			rnd = $random(seed);
			words.push_back(rnd);
		end
		sd_frame_model(words, wide);
		idx = 0;
		i_cfg_width = wide ? WIDTH_4W : WIDTH_1W;
		i_s_valid = 1'b1;
		i_s_data = words[0];
		i_s_last = (nwords == 1);
		while (idx < nwords) begin
			@(negedge i_clk);
			accepted = o_s_ready && i_s_valid;
			next_cycle();
			if (accepted) begin
				idx++;
				if (idx < nwords) begin
					i_s_data = words[idx];
					i_s_last = (idx == nwords - 1);
				end else begin
					i_s_valid = 1'b0;
					i_s_last = 1'b0;
					i_s_data = '0;
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Bus monitor and compare
	////////////////////////////////////////

	always @(posedge i_clk)
		strobe_at_edge <= i_ckstb;

	always @(negedge i_clk) begin
		if (!i_reset) begin
			// Idle lines sit high
			if (!o_tx_valid)
				check_value("o_tx_data", o_tx_data, '1);
			if (strobe_at_edge) begin
				if (o_tx_valid) begin
					if (exp_q.size() == 0) begin
						$display("Slot %h sent at %0t ns with nothing left in the model",
							o_tx_data, $time);
						abort_run();
					end else begin
						check_value("o_tx_data", o_tx_data, exp_q.pop_front());
					end
				end
			end else begin
				// No strobe on the last edge, so the bus must hold
				check_value("o_tx_data", o_tx_data, last_data);
				check_value("o_tx_valid", o_tx_valid, last_valid);
			end
		end
		last_data = o_tx_data;
		last_valid = o_tx_valid;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog ran out after %0d cycles, the frames never finished",
			WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		seed = 32'hade;
		strobe_at_edge = 1'b0;
		last_data = '1;
		last_valid = 1'b0;
		i_reset = 1'b1;
		i_cfg_width = WIDTH_1W;
		i_en = 1'b0;
		i_ckstb = 1'b0;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_last = 1'b0;
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		// Quiet bus after reset while disabled
		repeat (8) begin
			@(negedge i_clk);
			check_value("o_s_ready", o_s_ready, 1'b0);
			check_value("o_tx_valid", o_tx_valid, 1'b0);
			check_value("o_tx_data", o_tx_data, '1);
			next_cycle();
		end
		i_en = 1'b1;

		// Widths alternate, frames back to back
		send_frame(1, 1'b0);
		send_frame(5, 1'b1);
		send_frame(3, 1'b0);
		send_frame(2, 1'b1);
		send_frame(4, 1'b0);

		// Last frame ends when o_tx_valid falls after its stop slot
		drained = 1'b0;
		while (!drained) begin
			@(negedge i_clk);
			drained = !o_tx_valid;
			next_cycle();
		end
		repeat (4) next_cycle();

		if (exp_q.size() != 0) begin
			$display("Run ended with %0d expected slots never sent", exp_q.size());
			abort_run();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// ==== project.f ====
+incdir+include
source/sd_tx_pkg.sv
source/sd_word_if.sv
source/sd_tx_framer.sv
source/sd_tx_crc.sv
source/sd_tx_serializer.sv
source/sd_tx_frame.sv
tests/tb_sd_tx_frame.sv
